// ==== mem_system_params.svh ====
// cache and memory geometry
`ifndef MEM_SYSTEM_PARAMS_SVH
`define MEM_SYSTEM_PARAMS_SVH

// processor address and data widths
`define MS_ADDR_W 16
`define MS_DATA_W 16

// address split: tag 15:11, index 10:3, word 2:1
`define MS_TAG_W 5
`define MS_INDEX_W 8

// words in one cache line
`define MS_WORDS 4

// main memory banking, bank picked by address bits 2:1
`define MS_BANKS 4
// cycles a bank stays busy after any access
`define MS_BANK_BUSY 4
// accepted read to data on the memory output
`define MS_RD_LAT 2

`endif

// ==== mem_system_pkg.sv ====
// shared cache types
`default_nettype none

`include "mem_system_params.svh"

package mem_system_pkg;

   // one data word
   typedef logic [`MS_DATA_W-1:0] word_t;

   // stored and requested tag
   typedef logic [`MS_TAG_W-1:0] tag_t;

   // set index into both ways
   typedef logic [`MS_INDEX_W-1:0] index_t;

   // controller FSM states
   typedef enum logic [2:0] {
      idle,
      compare,
      write_back,
      fill_req,
      fill_wait,
      install,
      finish
   } ctrl_state_e;

endpackage

`default_nettype wire

// ==== cache_way.sv ====
// one cache way
`timescale 1ns/100ps
`default_nettype none

`include "mem_system_params.svh"

module cache_way (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   enable,
   input  logic                   write,
   input  logic                   valid_in,
   input  logic                   dirty_in,
   input  mem_system_pkg::index_t index,
   input  mem_system_pkg::tag_t   tag,
   input  logic [1:0]             word_sel,
   input  mem_system_pkg::word_t  data_in,
   output logic                   hit,
   output logic                   valid,
   output logic                   dirty,
   output mem_system_pkg::tag_t   tag_out,
   output mem_system_pkg::word_t  data_out
);

   import mem_system_pkg::*;

   localparam int SETS = 1 << `MS_INDEX_W;

   // per-set line state
   tag_t            tag_mem [SETS];
   logic [SETS-1:0] valid_bits;
   logic [SETS-1:0] dirty_bits;

   // line data, set and word flattened
   word_t           data_mem [SETS*`MS_WORDS];

   // write strobe for this way only
   logic            we;

   assign we = enable & write;

   // valid bits are the only state that must start clear
   always_ff @(posedge clk) begin
      if (reset) begin
         valid_bits <= '0;
      end else if (we) begin
         valid_bits[index] <= valid_in;
      end
   end

   // tag, dirty and one word per write
   always_ff @(posedge clk) begin
      if (we) begin
         tag_mem[index]              <= tag;
         dirty_bits[index]           <= dirty_in;
         data_mem[{index, word_sel}] <= data_in;
      end
   end

   // combinational look-up of the addressed set
   assign valid    = valid_bits[index];
   assign dirty    = dirty_bits[index];
   assign tag_out  = tag_mem[index];
   assign data_out = data_mem[{index, word_sel}];

   // an invalid line never hits, whatever its stale tag
   assign hit = valid & (tag_out == tag);

endmodule

`default_nettype wire

// ==== four_bank_mem.sv ====
// four-bank main memory
`timescale 1ns/100ps
`default_nettype none

`include "mem_system_params.svh"

module four_bank_mem (
   input  logic                  clk,
   input  logic                  reset,
   input  logic [`MS_ADDR_W-1:0] addr,
   input  mem_system_pkg::word_t data_in,
   input  logic                  rd,
   input  logic                  wr,
   output mem_system_pkg::word_t data_out,
   output logic                  stall
);

   import mem_system_pkg::*;

   localparam int BANK_W = $clog2(`MS_BANKS);
   localparam int ROW_W  = `MS_ADDR_W - BANK_W - 1;
   localparam int ROWS   = 1 << ROW_W;
   localparam int CNT_W  = $clog2(`MS_BANK_BUSY + 1);

   // word storage, all zero at start
   word_t             bank_mem [`MS_BANKS][ROWS] = '{default: '0};

   // per-bank busy down-counters
   logic [CNT_W-1:0]  busy_cnt [`MS_BANKS];

   // address decode
   logic [BANK_W-1:0] bank;
   logic [ROW_W-1:0]  row;
   logic              accept;

   // read data pipeline, one stage per cycle of latency
   word_t             rd_pipe [`MS_RD_LAT];

   // low word bits pick the bank so a line spreads over all banks
   assign bank = addr[BANK_W:1];
   assign row  = addr[`MS_ADDR_W-1:BANK_W+1];

   // addressed bank still recovering
   assign stall  = (busy_cnt[bank] != '0);
   assign accept = (rd | wr) & ~stall;

   // load on access, count down to idle
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int b = 0; b < `MS_BANKS; b++) begin
            busy_cnt[b] <= '0;
         end
      end else begin
         for (int b = 0; b < `MS_BANKS; b++) begin
            if (accept && (bank == b)) begin
               busy_cnt[b] <= CNT_W'(`MS_BANK_BUSY);
            end else if (busy_cnt[b] != '0) begin
               busy_cnt[b] <= busy_cnt[b] - 1'b1;
            end
         end
      end
   end

   // array write
   always_ff @(posedge clk) begin
      if (accept && wr) begin
         bank_mem[bank][row] <= data_in;
      end
   end

   // reads shift through freely, several may be in flight
   always_ff @(posedge clk) begin
      rd_pipe[0] <= bank_mem[bank][row];
      for (int i = 1; i < `MS_RD_LAT; i++) begin
         rd_pipe[i] <= rd_pipe[i-1];
      end
   end

   // last stage is the read result
   assign data_out = rd_pipe[`MS_RD_LAT-1];

endmodule

`default_nettype wire

// ==== cache_controller.sv ====
// two-way cache controller
`timescale 1ns/100ps
`default_nettype none

`include "mem_system_params.svh"

module cache_controller (
   input  logic                                  clk,
   input  logic                                  reset,
   input  logic                                  rd,
   input  logic                                  wr,
   input  logic [`MS_ADDR_W-1:0]                 addr,
   input  mem_system_pkg::word_t                 data_in,
   input  logic                                  hit0,
   input  logic                                  valid0,
   input  logic                                  dirty0,
   input  mem_system_pkg::tag_t                  tag0,
   input  mem_system_pkg::word_t                 data0,
   input  logic                                  hit1,
   input  logic                                  valid1,
   input  logic                                  dirty1,
   input  mem_system_pkg::tag_t                  tag1,
   input  mem_system_pkg::word_t                 data1,
   input  mem_system_pkg::word_t                 mem_data_out,
   input  logic                                  mem_stall,
   output mem_system_pkg::index_t                index,
   output mem_system_pkg::tag_t                  tag,
   output logic [$clog2(`MS_WORDS)-1:0]          word_sel,
   output mem_system_pkg::word_t                 way_data_in,
   output logic                                  way_write,
   output logic                                  way_valid_in,
   output logic                                  way_dirty_in,
   output logic                                  way_enable0,
   output logic                                  way_enable1,
   output logic [`MS_ADDR_W-1:0]                 mem_addr,
   output mem_system_pkg::word_t                 mem_wr_data,
   output logic                                  mem_rd,
   output logic                                  mem_wr,
   output mem_system_pkg::word_t                 data_out,
   output logic                                  done,
   output logic                                  stall,
   output logic                                  cache_hit,
   output logic                                  err
);

   import mem_system_pkg::*;

   localparam int OFS_W = $clog2(`MS_WORDS);

   ctrl_state_e      state;
   ctrl_state_e      next_state;

   // replacement and miss bookkeeping
   logic             victim;
   logic             way_sel;
   logic             miss_pend;
   logic [OFS_W-1:0] cnt;

   // decoded request
   logic [OFS_W-1:0] req_word;
   logic             bad_req;
   logic             hit_any;
   logic             first_cmp;
   logic             last_word;

   // way picked now, and its outputs
   logic             choice;
   logic             cur_way;
   logic             cur_valid;
   logic             cur_dirty;
   tag_t             cur_tag;
   word_t            cur_data;

   // address split, inputs are held until done
   assign tag      = addr[`MS_ADDR_W-1 -: `MS_TAG_W];
   assign index    = addr[`MS_ADDR_W-`MS_TAG_W-1 -: `MS_INDEX_W];
   assign req_word = addr[OFS_W:1];

   assign bad_req   = (rd & wr) | addr[0];
   assign hit_any   = hit0 | hit1;
   assign first_cmp = (state == compare) & ~miss_pend;
   assign last_word = (cnt == OFS_W'(`MS_WORDS - 1));

   // hit way first, then an empty way (way 0 preferred), then the victim bit
   always_comb begin
      if (hit0) begin
         choice = 1'b0;
      end else if (hit1) begin
         choice = 1'b1;
      end else if (!valid0) begin
         choice = 1'b0;
      end else if (!valid1) begin
         choice = 1'b1;
      end else begin
         choice = victim;
      end
   end

   // registered choice holds for the rest of a miss
   assign cur_way   = first_cmp ? choice : way_sel;
   assign cur_valid = cur_way ? valid1 : valid0;
   assign cur_dirty = cur_way ? dirty1 : dirty0;
   assign cur_tag   = cur_way ? tag1 : tag0;
   assign cur_data  = cur_way ? data1 : data0;

   // way side
   assign way_enable0  = ~cur_way;
   assign way_enable1  = cur_way;
   assign word_sel     = ((state == write_back) || (state == install)) ? cnt : req_word;
   assign way_data_in  = (state == install) ? mem_data_out : data_in;
   assign way_write    = (state == install) | ((state == compare) & wr & hit_any);
   assign way_valid_in = way_write;
   // fill words come in clean, processor writes mark dirty
   assign way_dirty_in = (state == compare);

   // memory side, write-back uses the victim's old tag
   assign mem_addr    = (state == write_back) ? {cur_tag, index, cnt, 1'b0}
                                              : {tag, index, cnt, 1'b0};
   assign mem_wr_data = cur_data;
   assign mem_wr      = (state == write_back);
   assign mem_rd      = (state == fill_req);

   // processor side
   assign data_out  = cur_data;
   assign cache_hit = first_cmp & hit_any;
   assign done      = cache_hit | (state == finish);
   assign err       = (state == finish) & bad_req;
   assign stall     = (state != idle) & ~done;

   always_comb begin
      next_state = state;
      case (state)
         idle: begin
            if (rd | wr) begin
               next_state = bad_req ? finish : compare;
            end
         end
         compare: begin
            // second pass after a fill always hits
            if (miss_pend) begin
               next_state = finish;
            end else if (hit_any) begin
               next_state = idle;
            end else if (cur_valid & cur_dirty) begin
               next_state = write_back;
            end else begin
               next_state = fill_req;
            end
         end
         write_back: begin
            if (!mem_stall && last_word) begin
               next_state = fill_req;
            end
         end
         fill_req: begin
            if (!mem_stall) begin
               next_state = fill_wait;
            end
         end
         // data lands two cycles after the accepted read
         fill_wait: next_state = install;
         install:   next_state = last_word ? compare : fill_req;
         finish:    next_state = idle;
         default:   next_state = idle;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state     <= idle;
         victim    <= 1'b0;
         way_sel   <= 1'b0;
         miss_pend <= 1'b0;
         cnt       <= '0;
      end else begin
         state <= next_state;
         // once per request
         if (first_cmp) begin
            victim    <= ~victim;
            way_sel   <= choice;
            miss_pend <= ~hit_any;
            cnt       <= '0;
         end
         if (state == finish) begin
            miss_pend <= 1'b0;
         end
         // word count holds while the bank stalls
         if (((state == write_back) && !mem_stall) || (state == install)) begin
            cnt <= cnt + 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// ==== mem_system.sv ====
// two-way cached memory system
`timescale 1ns/100ps
`default_nettype none

`include "mem_system_params.svh"

module mem_system (
   input  logic                  clk,
   input  logic                  reset,
   input  logic [`MS_ADDR_W-1:0] addr,
   input  mem_system_pkg::word_t data_in,
   input  logic                  rd,
   input  logic                  wr,
   output mem_system_pkg::word_t data_out,
   output logic                  done,
   output logic                  stall,
   output logic                  cache_hit,
   output logic                  err
);

   import mem_system_pkg::*;

   // shared way controls
   index_t                index;
   tag_t                  tag;
   logic [1:0]            word_sel;
   word_t                 way_data_in;
   logic                  way_write;
   logic                  way_valid_in;
   logic                  way_dirty_in;
   logic                  way_enable0;
   logic                  way_enable1;

   // way 0 results
   logic                  hit0;
   logic                  valid0;
   logic                  dirty0;
   tag_t                  tag0;
   word_t                 data0;

   // way 1 results
   logic                  hit1;
   logic                  valid1;
   logic                  dirty1;
   tag_t                  tag1;
   word_t                 data1;

   // memory port
   logic [`MS_ADDR_W-1:0] mem_addr;
   word_t                 mem_wr_data;
   logic                  mem_rd;
   logic                  mem_wr;
   word_t                 mem_data_out;
   logic                  mem_stall;

   cache_way way0 (
      .clk(clk), .reset(reset), .enable(way_enable0), .write(way_write),
      .valid_in(way_valid_in), .dirty_in(way_dirty_in), .index(index), .tag(tag),
      .word_sel(word_sel), .data_in(way_data_in), .hit(hit0), .valid(valid0),
      .dirty(dirty0), .tag_out(tag0), .data_out(data0)
   );

   cache_way way1 (
      .clk(clk), .reset(reset), .enable(way_enable1), .write(way_write),
      .valid_in(way_valid_in), .dirty_in(way_dirty_in), .index(index), .tag(tag),
      .word_sel(word_sel), .data_in(way_data_in), .hit(hit1), .valid(valid1),
      .dirty(dirty1), .tag_out(tag1), .data_out(data1)
   );

   // write-back data is the selected way's word
   cache_controller ctrl (
      .clk(clk), .reset(reset), .rd(rd), .wr(wr), .addr(addr), .data_in(data_in),
      .hit0(hit0), .valid0(valid0), .dirty0(dirty0), .tag0(tag0), .data0(data0),
      .hit1(hit1), .valid1(valid1), .dirty1(dirty1), .tag1(tag1), .data1(data1),
      .mem_data_out(mem_data_out), .mem_stall(mem_stall),
      .index(index), .tag(tag), .word_sel(word_sel), .way_data_in(way_data_in),
      .way_write(way_write), .way_valid_in(way_valid_in), .way_dirty_in(way_dirty_in),
      .way_enable0(way_enable0), .way_enable1(way_enable1),
      .mem_addr(mem_addr), .mem_wr_data(mem_wr_data), .mem_rd(mem_rd), .mem_wr(mem_wr),
      .data_out(data_out), .done(done), .stall(stall), .cache_hit(cache_hit), .err(err)
   );

   four_bank_mem mem (
      .clk(clk), .reset(reset), .addr(mem_addr), .data_in(mem_wr_data),
      .rd(mem_rd), .wr(mem_wr), .data_out(mem_data_out), .stall(mem_stall)
   );

endmodule

`default_nettype wire

// ==== tb_mem_system.sv ====
// two-way cache testbench
`timescale 1ns/100ps
`default_nettype none

`include "mem_system_params.svh"

module tb_mem_system;

   import mem_system_pkg::*;

   // 400 accesses at 40 cycles worst case, plus margin
   localparam int MAX_CYCLES = 20000;

   logic                  clk = 1'b0;
   logic                  reset = 1'b1;
   logic [`MS_ADDR_W-1:0] addr = '0;
   word_t                 data_in = '0;
   logic                  rd = 1'b0;
   logic                  wr = 1'b0;
   word_t                 data_out;
   logic                  done;
   logic                  stall;
   logic                  cache_hit;
   logic                  err;

   // reference model: flat memory image plus tag state of both ways
   word_t                 shadow [1 << `MS_ADDR_W];
   tag_t                  m_tag [2][1 << `MS_INDEX_W];
   logic                  m_valid [2][1 << `MS_INDEX_W];
   logic                  m_dirty [2][1 << `MS_INDEX_W];
   // one victim bit for the whole cache
   logic                  m_victim;

   // last DUT response, for the directed tests
   logic                  last_hit;
   // latency of the latest clean miss, reference for write-back cost
   int                    clean_lat = 0;
   int                    cycles = 0;

   mem_system i_mem_system (
      .clk(clk), .reset(reset), .addr(addr), .data_in(data_in), .rd(rd), .wr(wr),
      .data_out(data_out), .done(done), .stall(stall), .cache_hit(cache_hit), .err(err)
   );

   always #2 clk = ~clk;

   // hang guard
   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         $display("timeout: a request did not complete within %0d cycles", MAX_CYCLES);
         $display("Finished with errors");
         $fatal(1, "run stopped by timeout");
      end
   end

   task automatic check_value(input string what, input logic [15:0] got,
                              input logic [15:0] exp);
      assert (got === exp) else begin
         $display("error: %0t ns: %s is %h, expected %h", $time, what, got, exp);
         $display("Finished with errors");
         $fatal(1, "stopped at first mismatch");
      end
   endtask

   task automatic check_at_least(input string what, input int got, input int least);
      assert (got >= least) else begin
         $display("error: %0t ns: %s is %0d, expected at least %0d", $time, what, got,
                  least);
         $display("Finished with errors");
         $fatal(1, "stopped at first mismatch");
      end
   endtask

   function automatic logic [15:0] make_addr(input tag_t t, input index_t i,
                                             input logic [1:0] w);
      make_addr = {t, i, w, 1'b0};
   endfunction

   // replacement rule, then the architectural effect of the access
   task automatic model_access(input logic [15:0] a, input word_t d, input logic r,
                               input logic w, output logic hit, output word_t rdata,
                               output logic bad, output logic wb);
      index_t idx;
      tag_t   tg;
      logic   h0;
      logic   h1;
      logic   way;
      idx = a[10:3];
      tg  = a[15:11];
      bad = (r & w) | a[0];
      hit = 1'b0;
      wb  = 1'b0;
      rdata = '0;
      if (!bad) begin
         h0  = m_valid[0][idx] && (m_tag[0][idx] == tg);
         h1  = m_valid[1][idx] && (m_tag[1][idx] == tg);
         hit = h0 | h1;
         if (h0) way = 1'b0;
         else if (h1) way = 1'b1;
         else if (!m_valid[0][idx]) way = 1'b0;
         else if (!m_valid[1][idx]) way = 1'b1;
         else way = m_victim;
         m_victim = ~m_victim;
         // a dirty victim goes back to memory first
         wb = !hit && m_valid[way][idx] && m_dirty[way][idx];
         // fill leaves the line clean
         if (!hit) begin
            m_tag[way][idx]   = tg;
            m_valid[way][idx] = 1'b1;
            m_dirty[way][idx] = 1'b0;
         end
         if (w) begin
            m_dirty[way][idx] = 1'b1;
            shadow[a] = d;
         end
         rdata = shadow[a];
      end
   endtask

   // called 1 ns after a rising edge, returns at the same point
   task automatic do_access(input logic [15:0] a, input word_t d, input logic r,
                            input logic w);
      logic  exp_hit;
      word_t exp_data;
      logic  exp_err;
      logic  exp_wb;
      int    lat;
      model_access(a, d, r, w, exp_hit, exp_data, exp_err, exp_wb);
      addr    = a;
      data_in = d;
      rd      = r;
      wr      = w;
      lat     = 0;
      // outputs sampled on the falling edge, away from input changes
      @(negedge clk);
      // request not taken yet, nothing in progress
      check_value($sformatf("stall before %h is taken", a), stall, 1'b0);
      while (!done) begin
         @(negedge clk);
         lat++;
         if (!done) begin
            check_value($sformatf("stall while %h is busy", a), stall, 1'b1);
         end
      end
      check_value($sformatf("err for %h", a), err, exp_err);
      check_value($sformatf("cache_hit for %h", a), cache_hit, exp_hit);
      if (r && !exp_err) check_value($sformatf("read data at %h", a), data_out, exp_data);
      if (exp_hit) check_value($sformatf("hit latency at %h", a), lat[15:0], 16'd1);
      // four write-back words, one memory access per cycle at best
      if (exp_wb) begin
         check_at_least($sformatf("write-back miss latency at %h", a), lat,
                        clean_lat + `MS_WORDS);
      end else if (!exp_hit && !exp_err) begin
         clean_lat = lat;
      end
      last_hit = cache_hit;
      @(posedge clk);
      #1;
      rd = 1'b0;
      wr = 1'b0;
   endtask

   task automatic cold_miss_then_hit();
      do_access(make_addr(5'd0, 8'd2, 2'd0), '0, 1'b1, 1'b0);
      check_value("cold read hit flag", last_hit, 1'b0);
      do_access(make_addr(5'd0, 8'd2, 2'd0), '0, 1'b1, 1'b0);
      check_value("repeat read hit flag", last_hit, 1'b1);
   endtask

   task automatic write_hit();
      do_access(make_addr(5'd0, 8'd2, 2'd1), 16'hbeef, 1'b0, 1'b1);
      check_value("write hit flag", last_hit, 1'b1);
      // written word and its neighbours in the line
      for (int i = 0; i < 4; i++) begin
         do_access(make_addr(5'd0, 8'd2, i[1:0]), '0, 1'b1, 1'b0);
      end
   endtask

   // third tag forces a replacement in a full set
   task automatic two_ways_victim();
      for (int t = 1; t <= 3; t++) do_access(make_addr(t[4:0], 8'd5, 2'd0), '0, 1'b1, 1'b0);
      for (int t = 1; t <= 3; t++) do_access(make_addr(t[4:0], 8'd5, 2'd0), '0, 1'b1, 1'b0);
   endtask

   task automatic dirty_write_back();
      do_access(make_addr(5'd1, 8'd9, 2'd2), word_t'($urandom), 1'b0, 1'b1);
      do_access(make_addr(5'd2, 8'd9, 2'd3), word_t'($urandom), 1'b0, 1'b1);
      // push both dirty lines out
      do_access(make_addr(5'd3, 8'd9, 2'd0), '0, 1'b1, 1'b0);
      do_access(make_addr(5'd4, 8'd9, 2'd0), '0, 1'b1, 1'b0);
      do_access(make_addr(5'd1, 8'd9, 2'd2), '0, 1'b1, 1'b0);
      check_value("evicted line hit flag", last_hit, 1'b0);
      do_access(make_addr(5'd2, 8'd9, 2'd3), '0, 1'b1, 1'b0);
   endtask

   task automatic error_cases();
      do_access(make_addr(5'd0, 8'd2, 2'd1) | 16'h0001, '0, 1'b1, 1'b0);
      do_access(make_addr(5'd0, 8'd2, 2'd1), 16'h1234, 1'b1, 1'b1);
      // line and data untouched
      do_access(make_addr(5'd0, 8'd2, 2'd1), '0, 1'b1, 1'b0);
      check_value("read after errors hit flag", last_hit, 1'b1);
   endtask

   task automatic random_mix();
      logic [15:0] a;
      logic        is_wr;
      for (int n = 0; n < 300; n++) begin
         a = make_addr(tag_t'($urandom % 4), index_t'(40 + $urandom % 3),
                       2'($urandom % 4));
         // either a read or a write, never both
         is_wr = 1'($urandom % 2);
         do_access(a, word_t'($urandom), ~is_wr, is_wr);
      end
   endtask

   initial begin
      void'($urandom(32'h6e0e_ed39));
      for (int i = 0; i < (1 << `MS_ADDR_W); i++) shadow[i] = '0;
      for (int i = 0; i < (1 << `MS_INDEX_W); i++) begin
         for (int w = 0; w < 2; w++) begin
            m_tag[w][i]   = '0;
            m_valid[w][i] = 1'b0;
            m_dirty[w][i] = 1'b0;
         end
      end
      m_victim = 1'b0;
      repeat (4) @(posedge clk);
      #1;
      reset = 1'b0;
      cold_miss_then_hit();
      write_hit();
      two_ways_victim();
      dirty_write_back();
      error_cases();
      random_mix();
      $display("Finished with no errors");
      $finish;
   end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+.
mem_system_pkg.sv
cache_way.sv
four_bank_mem.sv
cache_controller.sv
mem_system.sv
tb_mem_system.sv
